// File: csr_unit.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_write_if.sv
verilog/csr_trap_setup.sv
verilog/csr_trap_handling.sv
verilog/csr_read_merge.sv
verilog/csr_unit.sv
tb/csr_unit_props.sv
tb/csr_unit_tb.sv

// File: Makefile
TOP := csr_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f csr_unit.f --top-module $(TOP)

# Pass or fail comes from the pass message in the simulation output.
run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: tb/csr_unit_tb.sv
`include "csr_settings.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int num_tests = 6;
    localparam int cycles_per_test = 200;

    logic        clk;
    logic        rst_n;
    logic [11:0] raddr;
    logic [11:0] waddr;
    logic [31:0] wdata;
    logic [1:0]  wop;
    logic        we;
    logic        trap_take;
    logic [31:0] trap_pc;
    logic [31:0] trap_cause;
    logic [31:0] trap_val;
    logic        mret;
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [31:0] rdata;
    logic        illegal;
    logic        irq_pending;
    logic [31:0] trap_vector;
    logic [31:0] epc;

    logic [31:0] lfsr_state = 32'h2848_2548;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    csr_unit dut0 (.*);

    bind csr_unit csr_unit_props props0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(num_tests * cycles_per_test * 8);
        $display("Watchdog timeout, the tests did not finish in time.");
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Galois LFSR, right shifting.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    function automatic logic [31:0] op_result(logic [31:0] old, logic [31:0] d, csr_op_e op);
        case (op)
            op_set:   return old | d;
            op_clear: return old & ~d;
            default:  return d;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("[%0d] %s: %s, %0d errors", tests_run, name,
                 (test_errors == 0) ? "pass" : "FAIL", test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // Result shows up one edge after the address.
    task automatic read_csr(logic [11:0] a, output logic [31:0] v, output logic ill);
        @(posedge clk);
        raddr <= a;
        @(posedge clk);
        @(negedge clk);
        v = rdata;
        ill = illegal;
    endtask

    task automatic check_read(string name, logic [11:0] a, logic [31:0] exp);
        logic [31:0] v;
        logic        ill;
        read_csr(a, v, ill);
        check_value(name, v, exp);
        check_value({name, " illegal"}, 32'(ill), 32'd0);
    endtask

    task automatic check_illegal(logic [11:0] a);
        logic [31:0] v;
        logic        ill;
        read_csr(a, v, ill);
        check_value("rdata on unknown address", v, 32'd0);
        check_value("illegal", 32'(ill), 32'd1);
    endtask

    task automatic write_csr(logic [11:0] a, logic [31:0] d, csr_op_e op);
        @(posedge clk);
        waddr <= a;
        wdata <= d;
        wop <= op;
        we <= 1'b1;
        @(posedge clk);
        we <= 1'b0;
    endtask

    // Read in the write cycle sees the old value, the next edge the new one.
    task automatic write_and_compare(string name, logic [11:0] a, logic [31:0] d,
                                     csr_op_e op, inout logic [31:0] model);
        @(posedge clk);
        raddr <= a;
        waddr <= a;
        wdata <= d;
        wop <= op;
        we <= 1'b1;
        @(posedge clk);
        we <= 1'b0;
        @(negedge clk);
        check_value({name, " in write cycle"}, rdata, model);
        model = op_result(model, d, op);
        @(posedge clk);
        @(negedge clk);
        check_value(name, rdata, model);
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] scratch;
        logic [31:0] vec;
        logic [31:0] status;
        logic [31:0] v;
        logic        ill;
        logic [31:0] pc;
        logic [31:0] cause;
        logic [31:0] val;
        rst_n <= 1'b0;
        raddr <= '0;
        waddr <= '0;
        wdata <= '0;
        wop <= op_write;
        we <= 1'b0;
        trap_take <= 1'b0;
        trap_pc <= '0;
        trap_cause <= '0;
        trap_val <= '0;
        mret <= 1'b0;
        irq_software <= 1'b0;
        irq_timer <= 1'b0;
        irq_external <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_value("rdata after reset", rdata, 32'd0);
        check_value("illegal after reset", 32'(illegal), 32'd0);
        check_value("irq_pending after reset", 32'(irq_pending), 32'd0);
        check_read("mvendorid", csr_mvendorid, `CSR_MVENDORID);
        check_read("marchid", csr_marchid, `CSR_MARCHID);
        check_read("mimpid", csr_mimpid, `CSR_MIMPID);
        check_read("mhartid", csr_mhartid, `CSR_MHARTID);
        check_read("misa", csr_misa, `CSR_MISA);
        finish_test("information reads");

        scratch = '0;
        vec = `CSR_MTVEC_RESET;
        for (int i = 1; i < 4; i++) begin // Write, set, clear.
            write_and_compare("mscratch", csr_mscratch, random_word(), csr_op_e'(i), scratch);
            write_and_compare("mtvec", csr_mtvec, random_word(), csr_op_e'(i), vec);
        end
        check_value("trap_vector", trap_vector, vec & ~32'h3);
        finish_test("write set clear");

        status = 32'd1 << mstatus_mie;
        write_csr(csr_mstatus, status, op_set);
        check_read("mstatus", csr_mstatus, status);
        pc = random_word();
        cause = random_word();
        val = random_word();
        @(posedge clk);
        trap_take <= 1'b1;
        trap_pc <= pc;
        trap_cause <= cause;
        trap_val <= val;
        waddr <= csr_mepc; // Lost to the trap.
        wdata <= random_word();
        wop <= op_write;
        we <= 1'b1;
        @(posedge clk);
        trap_take <= 1'b0;
        we <= 1'b0;
        status = 32'(status[mstatus_mie]) << mstatus_mpie;
        check_read("mepc", csr_mepc, pc & ~32'h3);
        check_value("epc", epc, pc & ~32'h3);
        check_read("mcause", csr_mcause, cause);
        check_read("mtval", csr_mtval, val);
        check_read("mstatus after trap", csr_mstatus, status);
        finish_test("trap entry");

        read_csr(csr_mstatus, v, ill);
        status = (32'(v[mstatus_mpie]) << mstatus_mie) | (32'd1 << mstatus_mpie);
        pulse_mret();
        check_read("mstatus after mret", csr_mstatus, status);
        write_csr(csr_mstatus, 32'd1 << mstatus_mpie, op_clear);
        read_csr(csr_mstatus, v, ill);
        status = (32'(v[mstatus_mpie]) << mstatus_mie) | (32'd1 << mstatus_mpie);
        pulse_mret();
        check_read("mstatus after second mret", csr_mstatus, status);
        finish_test("mret");

        write_csr(csr_mie, 32'hffff_ffff, op_write);
        check_read("mie", csr_mie,
                   (32'd1 << irq_msi) | (32'd1 << irq_mti) | (32'd1 << irq_mei));
        write_csr(csr_mie, 32'd1 << irq_mei, op_write);
        write_csr(csr_mstatus, 32'd1 << mstatus_mie, op_set);
        @(posedge clk);
        irq_timer <= 1'b1; // Not enabled in mie.
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("irq_pending with timer masked", 32'(irq_pending), 32'd0);
        @(posedge clk);
        irq_external <= 1'b1;
        @(negedge clk);
        check_value("irq_pending before sampling edge", 32'(irq_pending), 32'd0);
        @(posedge clk);
        @(negedge clk);
        check_value("irq_pending", 32'(irq_pending), 32'd1);
        check_read("mip", csr_mip, (32'd1 << irq_mti) | (32'd1 << irq_mei));
        write_csr(csr_mstatus, 32'd1 << mstatus_mie, op_clear);
        @(negedge clk);
        check_value("irq_pending with MIE 0", 32'(irq_pending), 32'd0);
        write_csr(csr_mstatus, 32'd1 << mstatus_mie, op_set);
        write_csr(csr_mie, 32'd1 << irq_mei, op_clear);
        @(negedge clk);
        check_value("irq_pending with mie 0", 32'(irq_pending), 32'd0);
        @(posedge clk);
        irq_timer <= 1'b0;
        irq_external <= 1'b0;
        finish_test("interrupt pending");

        check_illegal(12'h7c0);
        check_illegal(12'h345);
        write_csr(csr_misa, random_word(), op_write);
        check_read("misa after write", csr_misa, `CSR_MISA);
        write_csr(csr_mhartid, random_word(), op_set);
        check_read("mhartid after write", csr_mhartid, `CSR_MHARTID);
        finish_test("illegal and read-only");

        $display("%0d tests, %0d with errors, %0d check errors, %0d property failures",
                 tests_run, tests_failed, errors, dut0.props0.fail_count);
        if (errors == 0 && dut0.props0.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/csr_unit_props.sv
module csr_unit_props
    import csr_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic [11:0] raddr,
    input logic [31:0] rdata,
    input logic        illegal,
    input logic        irq_pending,
    input logic        irq_software,
    input logic        irq_timer,
    input logic        irq_external,
    input logic        we,
    input logic        trap_take,
    input logic [31:0] trap_pc,
    input logic        mret,
    input logic [31:0] epc,
    input logic [31:0] trap_vector,
    input logic        global_ie,
    input csr_word_t   mie_bits,
    input csr_word_t   mip_bits
);

    int fail_count = 0;

    function automatic logic known_addr(logic [11:0] a);
        return a inside {csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid,
                         csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mcounteren,
                         csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip};
    endfunction

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    a_unknown: assert property (@(posedge clk) disable iff (!rst_n)
        !known_addr(raddr) |=> illegal && rdata == '0)
    else begin
        $error("Unknown CSR address not flagged or returned nonzero data.");
        fail_count++;
    end

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        known_addr(raddr) |=> !illegal)
    else begin
        $error("Known CSR address flagged as illegal.");
        fail_count++;
    end

    // Trap entry aligns mepc and turns interrupts off.
    a_trap: assert property (@(posedge clk) disable iff (!rst_n)
        trap_take |=> epc == ($past(trap_pc) & ~32'h3) && !global_ie)
    else begin
        $error("Trap entry did not load epc or clear MIE.");
        fail_count++;
    end

    // Only a software write can move mtvec.
    a_vector_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !we |=> trap_vector == $past(trap_vector))
    else begin
        $error("Trap vector changed without a software write.");
        fail_count++;
    end

    // ------------------------------------------------------------------------
    // Interrupts
    // ------------------------------------------------------------------------

    a_mip: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> mip_bits[irq_mei] == $past(irq_external))
    else begin
        $error("mip external bit does not follow the line.");
        fail_count++;
    end

    a_irq_rise: assert property (@(posedge clk) disable iff (!rst_n)
        irq_external && mie_bits[irq_mei] && global_ie && !we && !trap_take && !mret
        |=> irq_pending)
    else begin
        $error("Enabled external interrupt did not raise irq_pending.");
        fail_count++;
    end

    a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n)
        !we && !(irq_software && mie_bits[irq_msi]) && !(irq_timer && mie_bits[irq_mti])
        && !(irq_external && mie_bits[irq_mei])
        |=> !irq_pending)
    else begin
        $error("irq_pending high with no enabled interrupt line.");
        fail_count++;
    end

endmodule

// File: verilog/csr_unit.sv
module csr_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] raddr,
    input  logic [11:0] waddr,
    input  logic [31:0] wdata,
    input  logic [1:0]  wop,
    input  logic        we,
    input  logic        trap_take,
    input  logic [31:0] trap_pc,
    input  logic [31:0] trap_cause,
    input  logic [31:0] trap_val,
    input  logic        mret,
    input  logic        irq_software,
    input  logic        irq_timer,
    input  logic        irq_external,
    output logic [31:0] rdata,
    output logic        illegal,
    output logic        irq_pending,
    output logic [31:0] trap_vector,
    output logic [31:0] epc
);

    csr_addr_e rd_addr;
    logic      setup_hit;
    csr_word_t setup_rd;
    logic      handling_hit;
    csr_word_t handling_rd;
    csr_word_t mie_bits;
    csr_word_t mip_bits;
    logic      global_ie;

    // ------------------------------------------------------------------------
    // Software write bundle
    // ------------------------------------------------------------------------

    csr_write_if wr_bus ();

    assign wr_bus.addr = csr_addr_e'(waddr);
    assign wr_bus.wdata = csr_word_t'(wdata);
    assign wr_bus.op = csr_op_e'(wop);
    assign wr_bus.we = we;

    assign rd_addr = csr_addr_e'(raddr); // Unknown codes pass through.

    csr_trap_setup u_setup (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr_bus.sink),
        .raddr       (rd_addr),
        .trap_take   (trap_take),
        .mret        (mret),
        .hit         (setup_hit),
        .rd          (setup_rd),
        .mie_bits    (mie_bits),
        .global_ie   (global_ie),
        .trap_vector (trap_vector)
    );

    csr_trap_handling u_handling (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (wr_bus.sink),
        .raddr        (rd_addr),
        .trap_take    (trap_take),
        .trap_pc      (trap_pc),
        .trap_cause   (trap_cause),
        .trap_val     (trap_val),
        .irq_software (irq_software),
        .irq_timer    (irq_timer),
        .irq_external (irq_external),
        .hit          (handling_hit),
        .rd           (handling_rd),
        .mip_bits     (mip_bits),
        .epc          (epc)
    );

    csr_read_merge u_merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .setup_hit    (setup_hit),
        .setup_rd     (setup_rd),
        .handling_hit (handling_hit),
        .handling_rd  (handling_rd),
        .mie_bits     (mie_bits),
        .mip_bits     (mip_bits),
        .global_ie    (global_ie),
        .rdata        (rdata),
        .illegal      (illegal),
        .irq_pending  (irq_pending)
    );

endmodule

// File: verilog/csr_read_merge.sv
module csr_read_merge
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      setup_hit,
    input  csr_word_t setup_rd,
    input  logic      handling_hit,
    input  csr_word_t handling_rd,
    input  csr_word_t mie_bits,
    input  csr_word_t mip_bits,
    input  logic      global_ie,
    output csr_word_t rdata,
    output logic      illegal,
    output logic      irq_pending
);

    csr_word_t rdata_next;
    logic      any_hit;
    logic      msi_pending;
    logic      mti_pending;
    logic      mei_pending;

    assign any_hit = setup_hit | handling_hit;

    always_comb begin
        if (setup_hit)
            rdata_next = setup_rd;
        else if (handling_hit)
            rdata_next = handling_rd;
        else
            rdata_next = '0; // Unknown address reads zero.
    end

    // ------------------------------------------------------------------------
    // Registered read result, one cycle after the address
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
            illegal <= 1'b0;
        end else begin
            rdata <= rdata_next;
            illegal <= !any_hit;
        end
    end

    // Pending level from registered mie, mip and mstatus.MIE.
    assign msi_pending = mie_bits[irq_msi] & mip_bits[irq_msi];
    assign mti_pending = mie_bits[irq_mti] & mip_bits[irq_mti];
    assign mei_pending = mie_bits[irq_mei] & mip_bits[irq_mei];

    assign irq_pending = global_ie & (msi_pending | mti_pending | mei_pending);

endmodule

// File: verilog/csr_trap_handling.sv
module csr_trap_handling
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_write_if.sink wr,
    input  csr_addr_e raddr,
    input  logic      trap_take,
    input  csr_word_t trap_pc,
    input  csr_word_t trap_cause,
    input  csr_word_t trap_val,
    input  logic      irq_software,
    input  logic      irq_timer,
    input  logic      irq_external,
    output logic      hit,
    output csr_word_t rd,
    output csr_word_t mip_bits,
    output csr_word_t epc
);

    // Instructions are word aligned, so mepc[1:0] is always zero.
    localparam csr_word_t pc_mask = ~csr_word_t'(3);

    csr_word_t mscratch_q;
    csr_word_t mepc_q;
    csr_word_t mcause_q;
    csr_word_t mtval_q;
    logic      msip_q;
    logic      mtip_q;
    logic      meip_q;

    logic sw_write;

    assign sw_write = wr.we && !trap_take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
        end else begin
            if (wr.we && wr.addr == csr_mscratch)
                mscratch_q <= csr_update(mscratch_q, wr.wdata, wr.op);
            if (trap_take) begin
                mepc_q <= trap_pc & pc_mask;
                mcause_q <= trap_cause;
                mtval_q <= trap_val;
            end
            if (sw_write && wr.addr == csr_mepc)
                mepc_q <= csr_update(mepc_q, wr.wdata, wr.op) & pc_mask;
            if (sw_write && wr.addr == csr_mcause)
                mcause_q <= csr_update(mcause_q, wr.wdata, wr.op);
            if (sw_write && wr.addr == csr_mtval)
                mtval_q <= csr_update(mtval_q, wr.wdata, wr.op);
        end
    end

    // Interrupt lines, sampled every cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_q <= 1'b0;
            mtip_q <= 1'b0;
            meip_q <= 1'b0;
        end else begin
            msip_q <= irq_software;
            mtip_q <= irq_timer;
            meip_q <= irq_external;
        end
    end

    always_comb begin
        mip_bits = '0;
        mip_bits[irq_msi] = msip_q;
        mip_bits[irq_mti] = mtip_q;
        mip_bits[irq_mei] = meip_q;
    end

    always_comb begin
        hit = 1'b1;
        rd = '0;
        case (raddr)
            csr_mscratch: rd = mscratch_q;
            csr_mepc:     rd = mepc_q;
            csr_mcause:   rd = mcause_q;
            csr_mtval:    rd = mtval_q;
            csr_mip:      rd = mip_bits; // Writes to mip are ignored.
            default:      hit = 1'b0;
        endcase
    end

    assign epc = mepc_q;

endmodule

// File: verilog/csr_trap_setup.sv
`include "csr_settings.svh"

module csr_trap_setup
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_write_if.sink wr,
    input  csr_addr_e raddr,
    input  logic      trap_take,
    input  logic      mret,
    output logic      hit,
    output csr_word_t rd,
    output csr_word_t mie_bits,
    output logic      global_ie,
    output csr_word_t trap_vector
);

    localparam csr_word_t mie_mask = (csr_word_t'(1) << irq_msi) |
                                     (csr_word_t'(1) << irq_mti) |
                                     (csr_word_t'(1) << irq_mei);

    logic      mstatus_mie_q;
    logic      mstatus_mpie_q;
    csr_word_t mie_q;
    csr_word_t mtvec_q;
    csr_word_t mcounteren_q;

    csr_word_t mstatus_word;
    csr_word_t mstatus_next;
    csr_word_t wr_result;

    // Only MIE and MPIE exist, all other mstatus bits read as zero.
    always_comb begin
        mstatus_word = '0;
        mstatus_word[mstatus_mie] = mstatus_mie_q;
        mstatus_word[mstatus_mpie] = mstatus_mpie_q;
    end

    assign mstatus_next = csr_update(mstatus_word, wr.wdata, wr.op);

    // ------------------------------------------------------------------------
    // mstatus, trap entry over mret over software write
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_q <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end else if (trap_take) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q <= 1'b0;
        end else if (mret) begin
            mstatus_mie_q <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (wr.we && wr.addr == csr_mstatus) begin
            mstatus_mie_q <= mstatus_next[mstatus_mie];
            mstatus_mpie_q <= mstatus_next[mstatus_mpie];
        end
    end

    // ------------------------------------------------------------------------
    // mie, mtvec and mcounteren
    // ------------------------------------------------------------------------

    always_comb begin
        case (wr.addr)
            csr_mie:        wr_result = csr_update(mie_q, wr.wdata, wr.op) & mie_mask;
            csr_mtvec:      wr_result = csr_update(mtvec_q, wr.wdata, wr.op);
            csr_mcounteren: wr_result = csr_update(mcounteren_q, wr.wdata, wr.op);
            default:        wr_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q <= '0;
            mtvec_q <= `CSR_MTVEC_RESET;
            mcounteren_q <= '0;
        end else if (wr.we) begin
            if (wr.addr == csr_mie) mie_q <= wr_result;
            if (wr.addr == csr_mtvec) mtvec_q <= wr_result;
            if (wr.addr == csr_mcounteren) mcounteren_q <= wr_result;
        end
    end

    // Read decode. Information registers and misa are constants.
    always_comb begin
        hit = 1'b1;
        rd = '0;
        case (raddr)
            csr_mvendorid:  rd = `CSR_MVENDORID;
            csr_marchid:    rd = `CSR_MARCHID;
            csr_mimpid:     rd = `CSR_MIMPID;
            csr_mhartid:    rd = `CSR_MHARTID;
            csr_mstatus:    rd = mstatus_word;
            csr_misa:       rd = `CSR_MISA;
            csr_mie:        rd = mie_q;
            csr_mtvec:      rd = mtvec_q;
            csr_mcounteren: rd = mcounteren_q;
            default:        hit = 1'b0;
        endcase
    end

    assign mie_bits = mie_q;
    assign global_ie = mstatus_mie_q;
    assign trap_vector = mtvec_q & ~csr_word_t'(3); // Direct mode only.

endmodule

// File: verilog/csr_write_if.sv
interface csr_write_if
    import csr_pkg::*;
();

    csr_addr_e addr;
    csr_word_t wdata;
    csr_op_e   op;
    logic      we; // One write per rising edge while high.

    // Driven from the top level ports.
    modport source (
        output addr,
        output wdata,
        output op,
        output we
    );

    // Each bank picks out its own addresses.
    modport sink (
        input addr,
        input wdata,
        input op,
        input we
    );

endinterface

// File: verilog/csr_pkg.sv
`include "csr_settings.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // Machine mode CSR addresses.
    typedef enum logic [11:0] {
        csr_mvendorid  = 12'hf11,
        csr_marchid    = 12'hf12,
        csr_mimpid     = 12'hf13,
        csr_mhartid    = 12'hf14,
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mcounteren = 12'h306,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344
    } csr_addr_e;

    // Same encoding as the low bits of funct3 in CSRRW, CSRRS and CSRRC.
    typedef enum logic [1:0] {
        op_write = 2'b01,
        op_set   = 2'b10,
        op_clear = 2'b11
    } csr_op_e;

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    localparam int irq_msi = 3; // Machine software interrupt.
    localparam int irq_mti = 7; // Machine timer interrupt.
    localparam int irq_mei = 11; // Machine external interrupt.

    // New register value for a software write.
    function automatic csr_word_t csr_update(csr_word_t old_value, csr_word_t operand,
                                             csr_op_e op);
        case (op)
            op_write: return operand;
            op_set:   return old_value | operand;
            op_clear: return old_value & ~operand;
            default:  return old_value; // Unused code, no change.
        endcase
    endfunction

endpackage

// File: verilog/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Data path
// ---------------------------------------------------------------------------

`define CSR_XLEN 32

// ---------------------------------------------------------------------------
// Machine information values, read only
// ---------------------------------------------------------------------------

`define CSR_MVENDORID 32'h0000_0000 // Non-commercial implementation.
`define CSR_MARCHID 32'h0000_0000
`define CSR_MIMPID 32'h0000_0001
`define CSR_MHARTID 32'h0000_0000 // Single hart.

// MXL = 1 (32 bit), extension I only.
`define CSR_MISA 32'h4000_0100

// ---------------------------------------------------------------------------
// Reset values
// ---------------------------------------------------------------------------

// Direct mode, so the low two bits stay zero.
`define CSR_MTVEC_RESET 32'h0000_0100

`endif
